//--- fir_core.sv
/*
  64-tap FIR core, one clock, no handshake on input or output.
  Avoid coeff_load while a pass is running; dout holds until the next result.
*/

`timescale 1ns/1ps

module fir_core (
  input  logic               clk2,
  input  logic               rstn,
  // Sample input
  input  fir_pkg::sample_t   sample_in,
  input  logic               sample_valid,
  // Coefficient load port
  input  fir_pkg::sample_t   coeff_data,
  input  fir_pkg::tap_addr_t coeff_addr,
  input  logic               coeff_load,
  // Result
  output fir_pkg::result_t   dout,
  output logic               valid_out
);

  import fir_pkg::*;

  // Memory reads
  sample_t   coeff_rdata;
  sample_t   window_rdata;
  logic      tap_ren;
  tap_addr_t coeff_raddr;
  tap_addr_t window_raddr;

  // Window writes
  logic      window_wen;
  tap_addr_t window_waddr;

  // MAC control and result
  logic      clr_acc;
  logic      en_mac;
  result_t   mac_result;

  // ============================================================
  // Memories
  // ============================================================

  // Written from outside, read by the sequencer
  fir_ram u_coeff_ram (
    .clk2  (clk2),
    .rstn  (rstn),
    .wen   (coeff_load),
    .waddr (coeff_addr),
    .wdata (coeff_data),
    .ren   (tap_ren),
    .raddr (coeff_raddr),
    .rdata (coeff_rdata)
  );

  // Circular window of the last 64 samples
  fir_ram u_window_ram (
    .clk2  (clk2),
    .rstn  (rstn),
    .wen   (window_wen),
    .waddr (window_waddr),
    .wdata (sample_in),
    .ren   (tap_ren),
    .raddr (window_raddr),
    .rdata (window_rdata)
  );

  // ============================================================
  // Datapath and control
  // ============================================================

  fir_mac u_mac (
    .clk2    (clk2),
    .rstn    (rstn),
    .clr_acc (clr_acc),
    .en_mac  (en_mac),
    .sample  (window_rdata),
    .coeff   (coeff_rdata),
    .result  (mac_result)
  );

  fir_sequencer u_seq (
    .clk2         (clk2),
    .rstn         (rstn),
    .sample_valid (sample_valid),
    .window_wen   (window_wen),
    .window_waddr (window_waddr),
    .window_raddr (window_raddr),
    .tap_ren      (tap_ren),
    .coeff_raddr  (coeff_raddr),
    .clr_acc      (clr_acc),
    .en_mac       (en_mac),
    .mac_result   (mac_result),
    .dout         (dout),
    .valid_out    (valid_out)
  );

endmodule

//--- fir_mac.sv
/*
  Signed 16x16 multiply into a 40-bit accumulator.
  Clear wins over accumulate; result is rounded to Q7.9 and clamped to 16 bits.
*/

`timescale 1ns/1ps

module fir_mac (
  input  logic             clk2,
  input  logic             rstn,
  input  logic             clr_acc,
  input  logic             en_mac,
  input  fir_pkg::sample_t sample,
  input  fir_pkg::sample_t coeff,
  output fir_pkg::result_t result
);

  import fir_pkg::*;

  logic signed [2*sample_w-1:0] product;
  acc_t                         product_ext;
  acc_t                         acc;
  acc_t                         acc_round;
  acc_t                         acc_shift;

  // ============================================================
  // Multiply and accumulate
  // ============================================================

  // Q1.15 times Q1.15 gives Q2.30
  assign product = sample * coeff;

  // Sign extend up to accumulator width
  assign product_ext = {{(acc_w - 2*sample_w){product[2*sample_w-1]}}, product};

  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      acc <= '0;
    end else if (clr_acc) begin
      acc <= '0;
    end else if (en_mac) begin
      acc <= acc + product_ext;
    end
  end

  // ============================================================
  // Round and saturate
  // ============================================================

  // Round half away from zero before the shift
  always_comb begin
    if (!acc[acc_w-1]) begin
      acc_round = acc + round_half;
    end else begin
      acc_round = acc - round_half;
    end
    acc_shift = acc_round >>> round_shift;
  end

  always_comb begin
    if (acc_shift > sat_max) begin
      result = result_t'(sat_max);
    end else if (acc_shift < sat_min) begin
      result = result_t'(sat_min);
    end else begin
      result = acc_shift[sample_w-1:0];
    end
  end

endmodule

//--- fir_pkg.sv
/*
  Shared widths, types and constants for the 64-tap FIR core.
  Samples and coefficients are Q1.15, results Q7.9, accumulation in 40 bits.
*/

package fir_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int num_taps    = 64;
  localparam int tap_addr_w  = 6;
  localparam int sample_w    = 16;
  localparam int acc_w       = 40;
  // Q2.30 product sum down to Q7.9
  localparam int round_shift = 21;
  // Must be able to hold num_taps itself
  localparam int tap_count_w = 7;

  // ============================================================
  // Vector types
  // ============================================================
  typedef logic signed [sample_w-1:0]   sample_t;
  typedef logic        [tap_addr_w-1:0] tap_addr_t;
  typedef logic signed [acc_w-1:0]      acc_t;
  typedef logic signed [sample_w-1:0]   result_t;

  // Rounding offset, half an output LSB
  localparam acc_t round_half = acc_t'(1) <<< (round_shift - 1);

  // Output clamp limits at accumulator width
  localparam acc_t sat_max = acc_t'(32767);
  localparam acc_t sat_min = -acc_t'(32768);

  // Sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_compute,
    st_output
  } fir_state_t;

endpackage

//--- fir_ram.sv
/*
  64x16 memory, one write port and one registered read port.
  Reset clears every entry; rdata holds its value while ren is low.
*/

`timescale 1ns/1ps

module fir_ram (
  input  logic              clk2,
  input  logic              rstn,
  input  logic              wen,
  input  fir_pkg::tap_addr_t waddr,
  input  fir_pkg::sample_t  wdata,
  input  logic              ren,
  input  fir_pkg::tap_addr_t raddr,
  output fir_pkg::sample_t  rdata
);

  import fir_pkg::*;

  sample_t mem [num_taps];

  // Reset clears every entry and the read register
  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      rdata <= '0;
      for (int i = 0; i < num_taps; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (wen) begin
        mem[waddr] <= wdata;
      end
      // Read sees the old word if the same address is written this edge
      if (ren) begin
        rdata <= mem[raddr];
      end
    end
  end

endmodule

//--- fir_sequencer.sv
/*
  Control for one MAC pass per accepted sample, 67 cycles to valid_out.
  sample_valid is only taken in idle; strobes during a pass are dropped.
*/

`timescale 1ns/1ps

module fir_sequencer (
  input  logic               clk2,
  input  logic               rstn,
  input  logic               sample_valid,
  // Sample window write and read
  output logic               window_wen,
  output fir_pkg::tap_addr_t window_waddr,
  output fir_pkg::tap_addr_t window_raddr,
  // Read enable for both memories
  output logic               tap_ren,
  output fir_pkg::tap_addr_t coeff_raddr,
  // MAC control
  output logic               clr_acc,
  output logic               en_mac,
  input  fir_pkg::result_t   mac_result,
  // Filter output
  output fir_pkg::result_t   dout,
  output logic               valid_out
);

  import fir_pkg::*;

  localparam logic [tap_count_w-1:0] last_count = tap_count_w'(num_taps);

  fir_state_t             state;
  fir_state_t             next_state;
  logic [tap_count_w-1:0] tap_count;
  tap_addr_t              wr_ptr;
  tap_addr_t              tap_idx;
  logic                   accept;
  logic                   pass_done;

  assign accept    = (state == st_idle) && sample_valid;
  assign pass_done = (state == st_compute) && (tap_count == last_count);
  assign tap_idx   = tap_count[tap_addr_w-1:0];

  // ============================================================
  // State register and next state
  // ============================================================

  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (sample_valid) begin
          next_state = st_compute;
        end
      end
      st_compute: begin
        // One count past the last tap to take its product
        if (tap_count == last_count) begin
          next_state = st_output;
        end
      end
      st_output: begin
        next_state = st_idle;
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  // ============================================================
  // Tap counter and circular write pointer
  // ============================================================

  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      tap_count <= '0;
    end else if (accept) begin
      tap_count <= '0;
    end else if ((state == st_compute) && !pass_done) begin
      tap_count <= tap_count + 1'b1;
    end
  end

  // Moves on once the result is taken; wraps at 64 by width
  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
    end else if (state == st_output) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // ============================================================
  // Memory and MAC strobes
  // ============================================================

  // New sample lands at the write pointer on the accepting edge
  assign window_wen   = accept;
  assign window_waddr = wr_ptr;

  // Counts 0 to 63 issue reads, bit 6 marks the drain count
  assign tap_ren      = (state == st_compute) && !tap_count[tap_count_w-1];
  assign coeff_raddr  = tap_idx;

  // Entry k steps back in the window, modulo 64
  assign window_raddr = wr_ptr - tap_idx;

  // Read data trails the address by one cycle
  assign clr_acc = (state == st_compute) && (tap_count == '0);
  assign en_mac  = (state == st_compute) && (tap_count != '0);

  // ============================================================
  // Output register
  // ============================================================

  always_ff @(posedge clk2 or negedge rstn) begin
    if (!rstn) begin
      dout      <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= (state == st_output);
      if (state == st_output) begin
        dout <= mac_result;
      end
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the FIR testbench with Verilator, runs it and checks the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_fir_core -o sim_fir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_fir)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

//--- sources.f
fir_pkg.sv
fir_ram.sv
fir_mac.sv
fir_sequencer.sv
fir_core.sv
tb_fir_core.sv

//--- tb_fir_core.sv
/*
  Directed testbench for the 64-tap FIR core with a bit-exact reference model.
  Expects valid_out in the 67th cycle after the accepting edge.
*/

`timescale 1ns/1ps

module tb_fir_core;

  import fir_pkg::*;

  // Total samples pushed by all tests, which sizes the watchdog
  localparam int n_samples  = 279;
  localparam int latency    = 67;
  localparam int timeout_ns = n_samples * 80 * 8;

  logic      clk2;
  logic      rstn;
  sample_t   sample_in;
  logic      sample_valid;
  sample_t   coeff_data;
  tap_addr_t coeff_addr;
  logic      coeff_load;
  result_t   dout;
  logic      valid_out;

  // Reference model state with hist[0] as the newest sample
  int          ref_coeff [64];
  int          hist [64];
  logic [31:0] rng_state;
  result_t     last_dout;
  int          errors;
  int          checks;

  fir_core dut0 (
    .clk2         (clk2),
    .rstn         (rstn),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .coeff_data   (coeff_data),
    .coeff_addr   (coeff_addr),
    .coeff_load   (coeff_load),
    .dout         (dout),
    .valid_out    (valid_out)
  );

  initial begin
    clk2 = 1'b0;
    forever #4 clk2 = ~clk2;
  end

  // ============================================================
  // Reference model and random numbers
  // ============================================================

  function automatic sample_t rand_sample();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x[15:0];
  endfunction

  // Sum of products then rounded, shifted by 21 and clamped
  function automatic result_t model_result();
    longint sum;
    longint r;
    sum = 0;
    for (int k = 0; k < num_taps; k++) begin
      sum = sum + longint'(ref_coeff[k]) * longint'(hist[k]);
    end
    if (sum >= 0) begin
      r = sum + 64'sd1048576;
    end else begin
      r = sum - 64'sd1048576;
    end
    r = r >>> 21;
    if (r > 32767) r = 32767;
    else if (r < -32768) r = -32768;
    return result_t'(r);
  endfunction

  // ============================================================
  // Driver tasks
  // ============================================================

  task automatic load_coeffs();
    for (int i = 0; i < num_taps; i++) begin
      coeff_load = 1'b1;
      coeff_addr = tap_addr_t'(i);
      coeff_data = sample_t'(ref_coeff[i]);
      @(posedge clk2);
      #1;
    end
    coeff_load = 1'b0;
  endtask

  // strobe_cyc > 0 raises sample_valid again in that cycle of the pass
  task automatic push_sample(input sample_t s, input int strobe_cyc);
    int      cyc;
    bit      seen;
    result_t exp;
    sample_in    = s;
    sample_valid = 1'b1;
    @(posedge clk2);
    #1;
    sample_valid = 1'b0;
    for (int k = num_taps - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0] = s;
    exp  = model_result();
    cyc  = 1;
    seen = 1'b0;
    while (!seen && cyc < 100) begin
      if (valid_out) begin
        seen = 1'b1;
      end else begin
        @(posedge clk2);
        #1;
        cyc++;
        sample_valid = (cyc == strobe_cyc);
        if (cyc == strobe_cyc) sample_in = 16'sh5a5a;
      end
    end
    sample_valid = 1'b0;
    checks++;
    assert (seen) else begin
      errors++;
      $display("valid_out did not rise within 100 cycles of the sample at %0t", $time);
    end
    if (seen) begin
      checks += 2;
      assert (cyc == latency) else begin
        errors++;
        $display("ERR t=%0t valid_out latency expected %0d got %0d", $time, latency, cyc);
      end
      assert (dout === exp) else begin
        errors++;
        $display("ERR t=%0t dout expected %0d got %0d", $time, exp, dout);
      end
      last_dout = dout;
      @(posedge clk2);
      #1;
      checks++;
      assert (!valid_out) else begin
        errors++;
        $display("valid_out stayed high longer than one cycle at %0t", $time);
      end
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(posedge clk2);
      #1;
      checks++;
      assert (!valid_out) else begin
        errors++;
        $display("valid_out pulsed with no sample pending at %0t", $time);
      end
    end
  endtask

  task automatic check_limit(input result_t want);
    checks++;
    assert (last_dout === want) else begin
      errors++;
      $display("ERR t=%0t dout expected %0d got %0d", $time, want, last_dout);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, errors - errs_before);
  endtask

  // ============================================================
  // Tests
  // ============================================================

  task automatic quiet_after_reset();
    int e0;
    e0 = errors;
    expect_quiet(10);
    // Output register comes out of reset at zero
    checks++;
    assert (dout === '0) else begin
      errors++;
      $display("ERR t=%0t dout expected 0 got %0d", $time, dout);
    end
    // Coefficient memory is still all zero
    push_sample(16'sd12345, 0);
    report_test("reset", e0);
  endtask

  task automatic impulse_response();
    int e0;
    e0 = errors;
    for (int i = 0; i < num_taps; i++) ref_coeff[i] = rand_sample();
    load_coeffs();
    push_sample(16'sd32767, 0);
    repeat (63) push_sample(16'sd0, 0);
    report_test("impulse", e0);
  endtask

  task automatic random_stream();
    int e0;
    e0 = errors;
    // More than 64 so the window pointer wraps
    repeat (80) push_sample(rand_sample(), 0);
    report_test("random_stream", e0);
  endtask

  task automatic saturate_output();
    int e0;
    e0 = errors;
    for (int i = 0; i < num_taps; i++) ref_coeff[i] = -32768;
    load_coeffs();
    // Full-scale negative squared lands one LSB above the range
    repeat (64) push_sample(sample_t'(-32768), 0);
    check_limit(16'sd32767);
    repeat (64) push_sample(16'sd32767, 0);
    check_limit(sample_t'(-32768));
    report_test("saturation", e0);
  endtask

  task automatic reload_with_strobes();
    int e0;
    e0 = errors;
    for (int i = 0; i < num_taps; i++) ref_coeff[i] = rand_sample();
    load_coeffs();
    push_sample(rand_sample(), 10);
    expect_quiet(80);
    for (int i = 0; i < num_taps; i++) ref_coeff[i] = rand_sample();
    load_coeffs();
    push_sample(rand_sample(), 40);
    expect_quiet(80);
    report_test("reload", e0);
  endtask

  task automatic measure_latency();
    int e0;
    e0 = errors;
    // Latency and pulse width are checked inside every push
    repeat (4) push_sample(rand_sample(), 0);
    report_test("latency", e0);
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================

  initial begin
    rng_state    = 32'd63;
    errors       = 0;
    checks       = 0;
    last_dout    = '0;
    rstn         = 1'b0;
    sample_in    = '0;
    sample_valid = 1'b0;
    coeff_data   = '0;
    coeff_addr   = '0;
    coeff_load   = 1'b0;
    for (int i = 0; i < num_taps; i++) begin
      ref_coeff[i] = 0;
      hist[i]      = 0;
    end
    repeat (5) @(posedge clk2);
    #1;
    rstn = 1'b1;
    quiet_after_reset();
    impulse_response();
    random_stream();
    saturate_output();
    reload_with_strobes();
    measure_latency();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("Errors found");
    $finish;
  end

endmodule
